// File: compile.f
verilog/rename_pkg.sv
verilog/rename_freelist.sv
verilog/rename_map.sv
verilog/rename_bypass.sv
verilog/rename_commit.sv
verilog/rename_top.sv
verification/tb_rename.sv

// File: run_sim.sh
#!/bin/sh
# build and run the rename testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --assert --timescale 1ns/100ps \
  -f compile.f --top-module tb_rename -Mdir "$build_dir"
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

"./$build_dir/Vtb_rename" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Simulation passed" "$log_file"; then
  exit 0
fi
echo "pass message not found in $log_file"
exit 1

// File: verification/tb_rename.sv
// rename stage testbench

`default_nettype none

module tb_rename;
  timeunit 1ns;
  timeprecision 100ps;
  import rename_pkg::*;

  localparam int depth          = 16;
  localparam int clk_period     = 4;
  localparam int reset_cycles   = 5;
  localparam int ready_wait_max = 8;
  // one cycle per group, two per commit, one reset per test
  localparam int group_count     = 1 + 6 + 1 + (depth + 1) + (3 + 1 + depth);
  localparam int commit_count    = 1 + 3;
  localparam int watchdog_cycles =
    2 * (5 * (reset_cycles + 1) + group_count + 2 * commit_count) + 20;

  logic                       clk;
  logic                       reset_n;
  logic                       front_valid;
  front_t                     front;
  logic                       front_ready;
  disp_inst_t [disp_size-1:0] disp;
  commit_t                    commit;

  // ------------------------------
  // reference model
  // ------------------------------
  rnid_t                      spec_map [arch_regs];
  rnid_t                      cmt_map  [arch_regs];
  rnid_t                      free_q   [disp_size][$];  // pop order
  cmt_lane_t                  inflight [$];             // renamed, not committed
  disp_inst_t [disp_size-1:0] last_disp;                // sampled in the fire cycle
  logic [31:0]                rng_state;
  int                         checks;
  int                         errors;

  rename_top #(
    .flist_depth (depth)
  ) dut (
    .i_clk         (clk),
    .i_reset_n     (reset_n),
    .i_front_valid (front_valid),
    .i_front       (front),
    .o_front_ready (front_ready),
    .o_disp        (disp),
    .i_commit      (commit)
  );

  always #(clk_period / 2) clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  // never x0
  function automatic regidx_t random_reg();
    rng_state = xorshift32(rng_state);
    return regidx_t'(rng_state % 32'd31 + 32'd1);
  endfunction

  function automatic front_inst_t make_inst(input logic rd_v, input regidx_t rd,
                                            input regidx_t rs1, input regidx_t rs2);
    front_inst_t inst;
    inst.valid        = 1'b1;
    inst.rd.valid     = rd_v;
    inst.rd.regidx    = rd;
    inst.rs[0].valid  = 1'b1;
    inst.rs[0].regidx = rs1;
    inst.rs[1].valid  = 1'b1;
    inst.rs[1].regidx = rs2;
    return inst;
  endfunction

  task automatic check_id(input string name, input rnid_t got, input rnid_t exp);
    checks++;
    assert (got == exp) else begin
      errors++;
      $display("Error: %s = %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    assert (got == exp) else begin
      errors++;
      $display("Error: %s = %h, expected %h", name, got, exp);
    end
  endtask

  // ------------------------------
  // drivers enter and leave on a falling edge
  // ------------------------------
  task automatic reset_dut();
    reset_n     = 1'b0;
    front_valid = 1'b0;
    front       = '0;
    commit      = '0;
    repeat (reset_cycles) @(negedge clk);
    reset_n = 1'b1;
    for (int i = 0; i < arch_regs; i++) begin
      spec_map[i] = rnid_t'(i);  // identity
      cmt_map[i]  = rnid_t'(i);
    end
    for (int d = 0; d < disp_size; d++) begin
      free_q[d].delete();
      for (int i = 0; i < depth; i++) begin
        free_q[d].push_back(rnid_t'(arch_regs + d * depth + i));
      end
    end
    inflight.delete();
  endtask

  task automatic rename_group(input front_t grp);
    int                    waited;
    logic  [disp_size-1:0] writes;
    rnid_t [disp_size-1:0] exp_new;
    rnid_t [disp_size-1:0] exp_old;
    rnid_t                 exp_src;
    cmt_lane_t             rec;
    front       = grp;
    front_valid = 1'b1;
    waited      = 0;
    while (!front_ready && waited < ready_wait_max) begin
      @(negedge clk);
      waited++;
    end
    assert (front_ready) else begin
      errors++;
      $display("rename group not accepted, ready stayed low for %0d cycles", waited);
    end
    if (!front_ready) begin
      front_valid = 1'b0;
      return;
    end
    #1;
    last_disp = disp;
    for (int d = 0; d < disp_size; d++) begin
      writes[d]  = grp[d].valid & grp[d].rd.valid & (grp[d].rd.regidx != '0);
      exp_new[d] = (grp[d].rd.regidx == '0) ? rnid_t'(0) : free_q[d][0];
      exp_old[d] = spec_map[grp[d].rd.regidx];
      for (int p = 0; p < d; p++) begin
        if (writes[p] && (grp[p].rd.regidx == grp[d].rd.regidx)) begin
          exp_old[d] = exp_new[p];
        end
      end
      check_bit($sformatf("o_disp[%0d].valid", d), disp[d].valid, grp[d].valid);
      if (grp[d].valid) begin
        for (int s = 0; s < 2; s++) begin
          exp_src = spec_map[grp[d].rs[s].regidx];
          for (int p = 0; p < d; p++) begin
            if (writes[p] && (grp[p].rd.regidx == grp[d].rs[s].regidx)) begin
              exp_src = exp_new[p];
            end
          end
          check_id($sformatf("o_disp[%0d].rs_rnid[%0d]", d, s), disp[d].rs_rnid[s], exp_src);
        end
        check_bit($sformatf("o_disp[%0d].rd_valid", d), disp[d].rd_valid, grp[d].rd.valid);
        if (grp[d].rd.valid) begin
          check_id($sformatf("o_disp[%0d].rd_rnid", d), disp[d].rd_rnid, exp_new[d]);
          check_id($sformatf("o_disp[%0d].rd_old_rnid", d), disp[d].rd_old_rnid, exp_old[d]);
        end
      end
    end
    // younger lane wins the map entry
    for (int d = 0; d < disp_size; d++) begin
      if (writes[d]) begin
        void'(free_q[d].pop_front());
        spec_map[grp[d].rd.regidx] = exp_new[d];
        rec.rd_valid  = 1'b1;
        rec.dead      = 1'b0;
        rec.rd_regidx = grp[d].rd.regidx;
        rec.new_rnid  = exp_new[d];
        rec.old_rnid  = exp_old[d];
        inflight.push_back(rec);
      end
    end
    @(negedge clk);  // group fired on the rising edge
    front_valid = 1'b0;
    front       = '0;
  endtask

  task automatic commit_group(input logic except, input cmt_lane_t [disp_size-1:0] lanes);
    logic ready_mid;
    logic ready_end;
    ready_mid = ~except;  // restore pending blocks rename
    for (int d = 0; d < disp_size; d++) begin
      if (free_q[d].size() == 0) begin
        ready_mid = 1'b0;
      end
    end
    commit.valid  = 1'b1;
    commit.except = except;
    commit.lane   = lanes;
    @(negedge clk);
    commit = '0;
    check_bit("o_front_ready", front_ready, ready_mid);
    for (int d = 0; d < disp_size; d++) begin
      if (lanes[d].rd_valid && (lanes[d].rd_regidx != '0)) begin
        if (lanes[d].dead || except) begin
          free_q[d].push_back(lanes[d].new_rnid);
        end else begin
          free_q[d].push_back(lanes[d].old_rnid);
          cmt_map[lanes[d].rd_regidx] = lanes[d].new_rnid;
        end
      end
    end
    if (except) begin
      for (int i = 0; i < arch_regs; i++) begin
        spec_map[i] = cmt_map[i];
      end
    end
    @(negedge clk);  // pushes and restore have landed
    ready_end = 1'b1;
    for (int d = 0; d < disp_size; d++) begin
      if (free_q[d].size() == 0) begin
        ready_end = 1'b0;
      end
    end
    check_bit("o_front_ready", front_ready, ready_end);
  endtask

  // ------------------------------
  // tests
  // ------------------------------
  task automatic test_reset_state();
    front_t grp;
    check_bit("o_front_ready", front_ready, 1'b1);
    grp[0] = make_inst(1'b0, 5'd0, random_reg(), random_reg());
    grp[1] = make_inst(1'b0, 5'd0, random_reg(), random_reg());
    rename_group(grp);
    for (int d = 0; d < disp_size; d++) begin
      for (int s = 0; s < 2; s++) begin
        check_id($sformatf("o_disp[%0d].rs_rnid[%0d]", d, s), last_disp[d].rs_rnid[s],
                 rnid_t'(grp[d].rs[s].regidx));
      end
    end
  endtask

  task automatic test_alloc_order();
    front_t  grp;
    regidx_t ra;
    ra     = random_reg();
    grp[0] = make_inst(1'b1, ra, random_reg(), random_reg());
    grp[1] = make_inst(1'b1, 5'd0, random_reg(), random_reg());  // x0 takes no id
    rename_group(grp);
    check_id("o_disp[0].rd_rnid", last_disp[0].rd_rnid, rnid_t'(arch_regs));
    check_id("o_disp[1].rd_rnid", last_disp[1].rd_rnid, rnid_t'(0));
    grp[0] = make_inst(1'b1, random_reg(), ra, random_reg());
    grp[1] = make_inst(1'b1, random_reg(), random_reg(), random_reg());
    rename_group(grp);
    check_id("o_disp[0].rs_rnid[0]", last_disp[0].rs_rnid[0], rnid_t'(arch_regs));
    check_id("o_disp[0].rd_rnid", last_disp[0].rd_rnid, rnid_t'(arch_regs + 1));
    check_id("o_disp[1].rd_rnid", last_disp[1].rd_rnid, rnid_t'(arch_regs + depth));
    repeat (4) begin
      grp[0] = make_inst(1'b1, random_reg(), random_reg(), random_reg());
      grp[1] = make_inst(1'b1, random_reg(), random_reg(), random_reg());
      rename_group(grp);
    end
  endtask

  task automatic test_same_group();
    front_t  grp;
    regidx_t ra;
    ra     = random_reg();
    grp[0] = make_inst(1'b1, ra, random_reg(), random_reg());
    grp[1] = make_inst(1'b1, ra, ra, random_reg());
    rename_group(grp);
    check_id("o_disp[1].rs_rnid[0]", last_disp[1].rs_rnid[0], rnid_t'(arch_regs));
    check_id("o_disp[1].rd_old_rnid", last_disp[1].rd_old_rnid, rnid_t'(arch_regs));
  endtask

  task automatic test_empty_list();
    front_t                    grp;
    cmt_lane_t [disp_size-1:0] lanes;
    rnid_t                     returned;
    grp[1] = '0;
    for (int i = 0; i < depth; i++) begin
      grp[0] = make_inst(1'b1, random_reg(), random_reg(), random_reg());
      rename_group(grp);
    end
    check_bit("o_front_ready", front_ready, 1'b0);
    lanes    = '0;
    lanes[0] = inflight.pop_front();
    returned = lanes[0].old_rnid;
    commit_group(1'b0, lanes);
    grp[0] = make_inst(1'b1, random_reg(), random_reg(), random_reg());
    rename_group(grp);
    check_id("o_disp[0].rd_rnid", last_disp[0].rd_rnid, returned);
  endtask

  task automatic test_exception();
    front_t                    grp;
    cmt_lane_t [disp_size-1:0] lanes;
    rnid_t [disp_size-1:0]     exc_new;
    regidx_t [disp_size-1:0]   cmt_rd;
    repeat (3) begin
      grp[0] = make_inst(1'b1, random_reg(), random_reg(), random_reg());
      grp[1] = make_inst(1'b1, random_reg(), random_reg(), random_reg());
      rename_group(grp);
    end
    repeat (2) begin
      lanes[0]  = inflight.pop_front();
      lanes[1]  = inflight.pop_front();
      cmt_rd[0] = lanes[0].rd_regidx;  // last live group kept by the commit
      cmt_rd[1] = lanes[1].rd_regidx;
      commit_group(1'b0, lanes);
    end
    lanes[0]   = inflight.pop_front();  // youngest group excepts
    lanes[1]   = inflight.pop_front();
    exc_new[0] = lanes[0].new_rnid;
    exc_new[1] = lanes[1].new_rnid;
    commit_group(1'b1, lanes);
    grp[0] = make_inst(1'b0, 5'd0, lanes[0].rd_regidx, lanes[1].rd_regidx);
    grp[1] = make_inst(1'b0, 5'd0, cmt_rd[0], cmt_rd[1]);
    rename_group(grp);
    check_id("o_disp[0].rs_rnid[0]", last_disp[0].rs_rnid[0], cmt_map[lanes[0].rd_regidx]);
    check_id("o_disp[0].rs_rnid[1]", last_disp[0].rs_rnid[1], cmt_map[lanes[1].rd_regidx]);
    check_id("o_disp[1].rs_rnid[0]", last_disp[1].rs_rnid[0], cmt_map[cmt_rd[0]]);
    check_id("o_disp[1].rs_rnid[1]", last_disp[1].rs_rnid[1], cmt_map[cmt_rd[1]]);
    // returned ids sit at the tail of each list
    repeat (depth) begin
      grp[0] = make_inst(1'b1, random_reg(), random_reg(), random_reg());
      grp[1] = make_inst(1'b1, random_reg(), random_reg(), random_reg());
      rename_group(grp);
    end
    check_id("o_disp[0].rd_rnid", last_disp[0].rd_rnid, exc_new[0]);
    check_id("o_disp[1].rd_rnid", last_disp[1].rd_rnid, exc_new[1]);
  endtask

  initial begin
    clk         = 1'b0;
    reset_n     = 1'b0;
    front_valid = 1'b0;
    front       = '0;
    commit      = '0;
    rng_state   = 32'hfe32_7114;
    checks      = 0;
    errors      = 0;
    reset_dut();
    test_reset_state();
    reset_dut();
    test_alloc_order();
    reset_dut();
    test_same_group();
    reset_dut();
    test_empty_list();
    reset_dut();
    test_exception();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(watchdog_cycles * clk_period);
    $display("watchdog expired after %0d cycles, tests did not finish", watchdog_cycles);
    $display("checks %0d, errors %0d", checks, errors);
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/rename_bypass.sv
// same-group forwarding and dispatch packing

`default_nettype none

module rename_bypass (
  input  rename_pkg::front_t                                  i_front,
  input  logic                                                i_fire,
  input  rename_pkg::rnid_t [rename_pkg::disp_size-1:0]       i_new_rnid,
  input  rename_pkg::rnid_t [rename_pkg::disp_size-1:0][1:0]  i_src_rnid,
  input  rename_pkg::rnid_t [rename_pkg::disp_size-1:0]       i_rd_old_rnid,
  output logic [rename_pkg::disp_size-1:0]                    o_wr_valid,
  output rename_pkg::regidx_t [rename_pkg::disp_size-1:0]     o_wr_regidx,
  output rename_pkg::rnid_t [rename_pkg::disp_size-1:0]       o_wr_rnid,
  output rename_pkg::disp_inst_t [rename_pkg::disp_size-1:0]  o_disp
);
  import rename_pkg::*;

  logic  [disp_size-1:0]      w_rd_wr;    // lane really writes a register
  rnid_t [disp_size-1:0]      w_rd_rnid;  // effective new id
  rnid_t [disp_size-1:0][1:0] w_src_fwd;
  rnid_t [disp_size-1:0]      w_old_fwd;

  // ------------------------------
  // effective destinations
  // ------------------------------
  always_comb begin
    for (int d = 0; d < disp_size; d++) begin
      w_rd_wr[d] = i_front[d].valid & i_front[d].rd.valid &
                   (i_front[d].rd.regidx != '0);
      // x0 never takes an id from the free list
      w_rd_rnid[d] = (i_front[d].rd.regidx == '0) ? '0 : i_new_rnid[d];
    end
  end

  // ------------------------------
  // forwarding
  // ------------------------------
  // scan older lanes oldest first so the nearest match is the one kept
  always_comb begin
    for (int d = 0; d < disp_size; d++) begin
      w_src_fwd[d] = i_src_rnid[d];
      w_old_fwd[d] = i_rd_old_rnid[d];
      for (int p = 0; p < d; p++) begin
        if (w_rd_wr[p]) begin
          for (int s = 0; s < 2; s++) begin
            if (i_front[p].rd.regidx == i_front[d].rs[s].regidx) begin
              w_src_fwd[d][s] = w_rd_rnid[p];
            end
          end
          if (i_front[p].rd.regidx == i_front[d].rd.regidx) begin
            w_old_fwd[d] = w_rd_rnid[p];  // WAW inside the group
          end
        end
      end
    end
  end

  // ------------------------------
  // map writes and result
  // ------------------------------
  always_comb begin
    for (int d = 0; d < disp_size; d++) begin
      o_wr_valid[d]  = i_fire & w_rd_wr[d];
      o_wr_regidx[d] = i_front[d].rd.regidx;
      o_wr_rnid[d]   = w_rd_rnid[d];

      o_disp[d].valid       = i_front[d].valid;
      o_disp[d].rd_valid    = i_front[d].rd.valid;
      o_disp[d].rd_rnid     = w_rd_rnid[d];
      o_disp[d].rd_old_rnid = w_old_fwd[d];
      o_disp[d].rs_rnid     = w_src_fwd[d];
    end
  end

endmodule

`default_nettype wire

// File: verilog/rename_commit.sv
// commit stage and committed map

`default_nettype none

module rename_commit (
  input  logic                                           i_clk,
  input  logic                                           i_reset_n,
  input  rename_pkg::commit_t                            i_commit,
  output logic [rename_pkg::disp_size-1:0]               o_push,
  output rename_pkg::rnid_t [rename_pkg::disp_size-1:0]  o_push_id,
  output logic                                           o_restore,
  output rename_pkg::rnid_t [rename_pkg::arch_regs-1:0]  o_restore_list
);
  import rename_pkg::*;

  logic                      r_valid;
  logic                      r_except;
  cmt_lane_t [disp_size-1:0] r_lane;     // lanes of the registered group
  rnid_t [arch_regs-1:0]     r_cmt_map;
  logic [disp_size-1:0]      w_has_rd;   // lane owns a renamed rd
  logic [disp_size-1:0]      w_map_upd;

  // ------------------------------
  // one cycle commit register
  // ------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid  <= 1'b0;
      r_except <= 1'b0;
    end else begin
      r_valid  <= i_commit.valid;
      r_except <= i_commit.valid & i_commit.except;
    end
  end

  always_ff @(posedge i_clk) begin
    r_lane <= i_commit.lane;
  end

  // ------------------------------
  // free list return
  // ------------------------------
  //   live, no exception  -> old id goes back, map keeps new id
  //   dead or exception   -> new id goes back, nothing committed
  always_comb begin
    for (int d = 0; d < disp_size; d++) begin
      w_has_rd[d]  = r_valid & r_lane[d].rd_valid & (r_lane[d].rd_regidx != '0);
      o_push[d]    = w_has_rd[d];
      o_push_id[d] = (r_lane[d].dead | r_except) ? r_lane[d].new_rnid
                                                  : r_lane[d].old_rnid;
      w_map_upd[d] = w_has_rd[d] & ~r_lane[d].dead & ~r_except;
    end
  end

  // ------------------------------
  // committed map
  // ------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int i = 0; i < arch_regs; i++) begin
        r_cmt_map[i] <= rnid_t'(i);
      end
    end else begin
      // younger lane last so it owns the final mapping
      for (int d = 0; d < disp_size; d++) begin
        if (w_map_upd[d]) begin
          r_cmt_map[r_lane[d].rd_regidx] <= r_lane[d].new_rnid;
        end
      end
    end
  end

  // restore fires on the same edge as the pushes of the excepting group
  assign o_restore      = r_except;
  assign o_restore_list = r_cmt_map;

endmodule

`default_nettype wire

// File: verilog/rename_freelist.sv
// physical id free list

`default_nettype none

module rename_freelist #(
  parameter int flist_depth = 16,
  parameter int init_base   = 32
) (
  input  logic              i_clk,
  input  logic              i_reset_n,
  input  logic              i_push,
  input  rename_pkg::rnid_t i_push_id,
  input  logic              i_pop,
  output rename_pkg::rnid_t o_pop_id,
  output logic              o_empty
);
  import rename_pkg::*;

  localparam int ptr_w = (flist_depth > 1) ? $clog2(flist_depth) : 1;
  localparam int cnt_w = $clog2(flist_depth + 1);

  rnid_t            r_list [flist_depth];
  logic [ptr_w-1:0] r_head;   // next id to pop
  logic [ptr_w-1:0] r_tail;   // next free slot for a push
  logic [cnt_w-1:0] r_count;
  logic             w_full;

  // wrap for depths that are not a power of two
  function automatic logic [ptr_w-1:0] ptr_next(input logic [ptr_w-1:0] ptr);
    if (ptr == ptr_w'(flist_depth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // list starts full, ids ascending from init_base
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int i = 0; i < flist_depth; i++) begin
        r_list[i] <= rnid_t'(init_base + i);
      end
      r_head  <= '0;
      r_tail  <= '0;
      r_count <= cnt_w'(flist_depth);
    end else begin
      if (i_push) begin
        r_list[r_tail] <= i_push_id;
        r_tail         <= ptr_next(r_tail);
      end
      if (i_pop) begin
        r_head <= ptr_next(r_head);
      end
      case ({i_push, i_pop})
        2'b10:   r_count <= r_count + 1'b1;
        2'b01:   r_count <= r_count - 1'b1;
        default: r_count <= r_count;  // both or neither
      endcase
    end
  end

  assign o_pop_id = r_list[r_head];
  assign o_empty  = (r_count == '0);
  assign w_full   = (r_count == cnt_w'(flist_depth));

  // ------------------------------
  // checks
  // ------------------------------
  // pop is qualified by the top level ready, which covers every lane
  a_no_pop_empty: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_pop |-> !o_empty)
    else $error("free list pop while empty");

  // a push into a full list means the commit side returned an id twice
  a_no_push_full: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_push |-> !w_full)
    else $error("free list push while full");

endmodule

`default_nettype wire

// File: verilog/rename_map.sv
// speculative rename map

`default_nettype none

module rename_map (
  input  logic                                                i_clk,
  input  logic                                                i_reset_n,
  input  rename_pkg::front_t                                  i_front,
  output rename_pkg::rnid_t [rename_pkg::disp_size-1:0][1:0]  o_src_rnid,
  output rename_pkg::rnid_t [rename_pkg::disp_size-1:0]       o_rd_old_rnid,
  input  logic [rename_pkg::disp_size-1:0]                    i_wr_valid,
  input  rename_pkg::regidx_t [rename_pkg::disp_size-1:0]     i_wr_regidx,
  input  rename_pkg::rnid_t [rename_pkg::disp_size-1:0]       i_wr_rnid,
  input  logic                                                i_restore,
  input  rename_pkg::rnid_t [rename_pkg::arch_regs-1:0]       i_restore_list
);
  import rename_pkg::*;

  rnid_t r_map [arch_regs];

  // ------------------------------
  // read ports
  // ------------------------------
  // x0 reads entry 0, which never leaves 0
  always_comb begin
    for (int d = 0; d < disp_size; d++) begin
      for (int s = 0; s < 2; s++) begin
        o_src_rnid[d][s] = r_map[i_front[d].rs[s].regidx];
      end
      o_rd_old_rnid[d] = r_map[i_front[d].rd.regidx];  // before any same-group forward
    end
  end

  // ------------------------------
  // update
  // ------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int i = 0; i < arch_regs; i++) begin
        r_map[i] <= rnid_t'(i);  // identity
      end
    end else begin
      for (int i = 1; i < arch_regs; i++) begin
        if (i_restore) begin
          r_map[i] <= i_restore_list[i];  // back to the committed state
        end else begin
          // ascending lane order, so the younger lane wins
          for (int d = 0; d < disp_size; d++) begin
            if (i_wr_valid[d] && (i_wr_regidx[d] == regidx_t'(i))) begin
              r_map[i] <= i_wr_rnid[d];
            end
          end
        end
      end
    end
  end

  // ------------------------------
  // checks
  // ------------------------------
  // ready is held low while the commit stage restores, so no rename can land then
  a_restore_no_write: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_restore |-> !(|i_wr_valid))
    else $error("map restore collides with a rename write");

endmodule

`default_nettype wire

// File: verilog/rename_pkg.sv
// rename stage shared types

`default_nettype none

package rename_pkg;

  // ------------------------------
  // sizes
  // ------------------------------
  localparam int disp_size       = 2;   // dispatch lanes
  localparam int arch_regs       = 32;  // integer architectural registers
  localparam int flist_depth_max = 16;  // 32 + 2 * 16 ids fill rnid_w
  localparam int rnid_w          = 6;

  typedef logic [rnid_w-1:0] rnid_t;   // physical register id
  typedef logic [4:0]        regidx_t; // architectural index

  // ------------------------------
  // front side
  // ------------------------------
  typedef struct packed {
    logic    valid;
    regidx_t regidx;
  } reg_ref_t;

  typedef struct packed {
    logic           valid;
    reg_ref_t       rd;
    reg_ref_t [1:0] rs;  // rs[0] = rs1, rs[1] = rs2
  } front_inst_t;

  typedef front_inst_t [disp_size-1:0] front_t;

  // renamed instruction as handed to dispatch
  typedef struct packed {
    logic        valid;
    logic        rd_valid;
    rnid_t       rd_rnid;      // 0 for an x0 destination
    rnid_t       rd_old_rnid;  // mapping replaced by this rd
    rnid_t [1:0] rs_rnid;
  } disp_inst_t;

  // ------------------------------
  // commit side
  // ------------------------------
  typedef struct packed {
    logic    rd_valid;
    logic    dead;      // squashed, never architecturally visible
    regidx_t rd_regidx;
    rnid_t   new_rnid;
    rnid_t   old_rnid;
  } cmt_lane_t;

  typedef struct packed {
    logic                        valid;
    logic                        except;
    cmt_lane_t [disp_size-1:0]   lane;
  } commit_t;

endpackage

`default_nettype wire

// File: verilog/rename_top.sv
// integer rename stage

`default_nettype none

module rename_top #(
  parameter int flist_depth = 16
) (
  input  logic                                               i_clk,
  input  logic                                               i_reset_n,
  input  logic                                               i_front_valid,
  input  rename_pkg::front_t                                 i_front,
  output logic                                               o_front_ready,
  output rename_pkg::disp_inst_t [rename_pkg::disp_size-1:0] o_disp,
  input  rename_pkg::commit_t                                i_commit
);
  import rename_pkg::*;

  front_t                     w_front;     // lane valids qualified by i_front_valid
  logic                       w_fire;
  logic  [disp_size-1:0]      w_empty;
  logic  [disp_size-1:0]      w_pop;
  logic  [disp_size-1:0]      w_push;
  rnid_t [disp_size-1:0]      w_pop_id;
  rnid_t [disp_size-1:0]      w_push_id;
  rnid_t [disp_size-1:0][1:0] w_src_rnid;
  rnid_t [disp_size-1:0]      w_rd_old_rnid;
  logic  [disp_size-1:0]      w_wr_valid;
  regidx_t [disp_size-1:0]    w_wr_regidx;
  rnid_t [disp_size-1:0]      w_wr_rnid;
  logic                       w_restore;
  rnid_t [arch_regs-1:0]      w_restore_list;

  // ids above 63 would not fit rnid_t
  if (flist_depth < 1 || flist_depth > flist_depth_max) begin : g_depth_check
    $error("flist_depth out of range");
  end

  // ------------------------------
  // flow control
  // ------------------------------
  assign o_front_ready = ~(|w_empty) & ~w_restore;  // restore cycle blocks rename
  assign w_fire        = i_front_valid & o_front_ready;

  always_comb begin
    w_front = i_front;
    for (int d = 0; d < disp_size; d++) begin
      w_front[d].valid = i_front[d].valid & i_front_valid;
      w_pop[d] = w_fire & w_front[d].valid & w_front[d].rd.valid &
                 (w_front[d].rd.regidx != '0);
    end
  end

  // ------------------------------
  // per lane free lists
  // ------------------------------
  for (genvar d = 0; d < disp_size; d++) begin : g_lane
    rename_freelist #(
      .flist_depth (flist_depth),
      .init_base   (arch_regs + d * flist_depth)
    ) u_freelist (
      .i_clk     (i_clk),
      .i_reset_n (i_reset_n),
      .i_push    (w_push[d]),
      .i_push_id (w_push_id[d]),
      .i_pop     (w_pop[d]),
      .o_pop_id  (w_pop_id[d]),
      .o_empty   (w_empty[d])
    );
  end

  rename_map u_map (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_front        (w_front),
    .o_src_rnid     (w_src_rnid),
    .o_rd_old_rnid  (w_rd_old_rnid),
    .i_wr_valid     (w_wr_valid),
    .i_wr_regidx    (w_wr_regidx),
    .i_wr_rnid      (w_wr_rnid),
    .i_restore      (w_restore),
    .i_restore_list (w_restore_list)
  );

  rename_bypass u_bypass (
    .i_front       (w_front),
    .i_fire        (w_fire),
    .i_new_rnid    (w_pop_id),
    .i_src_rnid    (w_src_rnid),
    .i_rd_old_rnid (w_rd_old_rnid),
    .o_wr_valid    (w_wr_valid),
    .o_wr_regidx   (w_wr_regidx),
    .o_wr_rnid     (w_wr_rnid),
    .o_disp        (o_disp)
  );

  rename_commit u_commit (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_commit       (i_commit),
    .o_push         (w_push),
    .o_push_id      (w_push_id),
    .o_restore      (w_restore),
    .o_restore_list (w_restore_list)
  );

endmodule

`default_nettype wire
